// File: list.f
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/l15_fetch_port.sv
verilog/fetch_queue.sv
verilog/fetch_stage.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module fetch_tb -f list.f -o fetch_sim \
	&& ./obj_dir/fetch_sim \
	|| { echo "build or simulation failed"; exit 1; }

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

	localparam logic [31:0] boot_addr = 32'h4000_0000;
	localparam int queue_depth    = 4;
	localparam int num_entries    = 300;
	localparam int timeout_cycles = 40 * num_entries;

	typedef enum logic [1:0] {c_idle, c_wait, c_fill, c_stray} cache_mode_t;

	logic                    clk;
	logic                    nrst;
	fetch_pkg::redirect_t    redirect;
	logic                    l15_ack;
	logic                    l15_header_ack;
	fetch_pkg::l15_resp_t    resp;
	logic                    out_ready;
	fetch_pkg::l15_req_t     req;
	logic                    l15_req_ack;
	logic                    out_valid;
	fetch_pkg::fetch_entry_t out_entry;

	logic [15:0] lfsr;
	cache_mode_t mode;
	logic [31:0] exp_pc;     // pc of the next entry decode should get
	logic [31:0] fire_addr;
	logic [31:0] prev_addr;
	logic        prev_val;
	logic        stale;      // redirect since the last fired request
	logic        stalled;    // decode stall phase
	int          delay;
	int          occ;        // queue count after the last rising edge
	int          occ_prev;
	int          popped;
	int          strays;
	int          redirects;
	int          cycles = 0;

	fetch_stage #(
		.BOOT_ADDR   (boot_addr),
		.QUEUE_DEPTH (queue_depth)
	) fetch_stage_i (
		.clk            (clk),
		.nrst           (nrst),
		.redirect       (redirect),
		.l15_ack        (l15_ack),
		.l15_header_ack (l15_header_ack),
		.resp           (resp),
		.out_ready      (out_ready),
		.req            (req),
		.l15_req_ack    (l15_req_ack),
		.out_valid      (out_valid),
		.out_entry      (out_entry)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Error: %s is %h, expected %h", name, actual, expected);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// checks outputs then drives the cache, decode and redirect inputs
	task automatic cycle_step();
		logic        rdir;
		logic        fire;
		logic        fill_acked;
		logic        stale_before;
		logic        pop;
		logic [31:0] target;
		fire         = 1'b0;
		fill_acked   = 1'b0;
		stale_before = stale;
		target       = '0;
		check_value("out_valid", 32'(out_valid), 32'(occ != 0));
		if (!resp.val)
			check_value("l15_req_ack", 32'(l15_req_ack), 32'd0);
		if (req.val && prev_val)
			check_value("req.address", req.address, prev_addr);
		if (req.val && !prev_val)
			check_value("queue full at req.val rise", 32'(occ_prev == queue_depth), 32'd0);
		if (req.val)
		begin
			check_value("req.rqtype", 32'(req.rqtype), 32'(fetch_pkg::rq_imiss));
			check_value("req.size", 32'(req.size), 32'd4);
		end
		prev_val  = req.val;
		prev_addr = req.address;

		rdir = (rand_bits(8) == 32'd0); // rare
		if (rdir)
			target = boot_addr + (rand_bits(16) << 2);
		redirect = '{valid: rdir, target: target};

		l15_ack        = 1'b0;
		l15_header_ack = 1'b0;
		case (mode)
			c_idle:
			begin
				l15_ack        = (rand_bits(1) != 32'd0);
				l15_header_ack = (rand_bits(2) != 32'd0);
				if (req.val && l15_ack && l15_header_ack)
				begin
					fire      = 1'b1;
					fire_addr = req.address;
					delay     = int'(rand_bits(2));
					mode      = c_wait;
				end
			end
			c_wait:
			begin
				if (delay == 0)
				begin
					resp = '{val: 1'b1, data: fire_addr ^ 32'hA5A5_A5A5,
						returntype: (rand_bits(1) != 32'd0) ? fetch_pkg::ret_load :
						fetch_pkg::ret_ifill};
					mode = c_fill;
				end
				else if (rand_bits(3) == 32'd0)
				begin
					resp = '{val: 1'b1, data: ~fire_addr,
						returntype: (rand_bits(1) != 32'd0) ? fetch_pkg::ret_st_ack :
						fetch_pkg::ret_err};
					strays++;
					mode = c_stray;
				end
				else
					delay--;
			end
			c_fill:
			begin
				if (l15_req_ack)
				begin
					resp.val   = 1'b0;
					fill_acked = 1'b1;
					mode       = c_idle;
				end
			end
			c_stray:
			begin
				if (l15_req_ack)
				begin
					resp.val = 1'b0; // back to waiting for the real fill
					mode     = c_wait;
				end
			end
		endcase
		if (fire)
			stale = rdir;
		else if (rdir)
			stale = 1'b1;

		if (rand_bits(6) == 32'd0)
			stalled = !stalled;
		out_ready = !stalled && (rand_bits(2) != 32'd0);
		pop = out_valid && out_ready;
		if (pop)
		begin
			check_value("out_entry.pc", out_entry.pc, exp_pc);
			check_value("out_entry.instr", out_entry.instr, exp_pc ^ 32'hA5A5_A5A5);
			exp_pc = exp_pc + 32'd4;
			popped++;
		end
		if (rdir)
		begin
			exp_pc = target; // old path entries are flushed
			redirects++;
		end

		occ_prev = occ;
		if (rdir)
			occ = 0;
		else
		begin
			if (fill_acked && !stale_before)
				occ++;
			if (pop)
				occ--;
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > timeout_cycles)
		begin
			$display("Timeout: %0d of %0d entries after %0d cycles",
				popped, num_entries, cycles);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	initial
	begin
		lfsr           = 16'd11754;
		nrst           = 1'b0;
		redirect       = '0;
		l15_ack        = 1'b0;
		l15_header_ack = 1'b0;
		resp           = '0;
		out_ready      = 1'b0;
		mode           = c_idle;
		exp_pc         = boot_addr;
		fire_addr      = '0;
		prev_addr      = '0;
		prev_val       = 1'b0;
		stale          = 1'b0;
		stalled        = 1'b0;
		delay          = 0;
		occ            = 0;
		occ_prev       = 0;
		popped         = 0;
		strays         = 0;
		redirects      = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;

		// asleep until the interrupt return
		repeat (10)
		begin
			@(negedge clk);
			check_value("req.val", 32'(req.val), 32'd0);
			check_value("l15_req_ack", 32'(l15_req_ack), 32'd0);
			check_value("out_valid", 32'(out_valid), 32'd0);
		end
		resp = '{val: 1'b1, returntype: fetch_pkg::ret_int, data: 32'd0};
		do
		begin
			@(negedge clk);
			check_value("req.val", 32'(req.val), 32'd0);
			check_value("out_valid", 32'(out_valid), 32'd0);
		end
		while (!l15_req_ack);
		resp.val = 1'b0;

		while (popped < num_entries)
		begin
			@(negedge clk);
			cycle_step();
		end
		$display("%0d entries, %0d stray responses, %0d redirects",
			popped, strays, redirects);
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
	parameter logic [31:0] BOOT_ADDR   = 32'h4000_0000,
	parameter int          QUEUE_DEPTH = 4
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  fetch_pkg::redirect_t    redirect,
	input  logic                    l15_ack,
	input  logic                    l15_header_ack,
	input  fetch_pkg::l15_resp_t    resp,
	input  logic                    out_ready,
	output fetch_pkg::l15_req_t     req,
	output logic                    l15_req_ack,
	output logic                    out_valid,
	output fetch_pkg::fetch_entry_t out_entry
);

	logic [31:0]             fetch_pc;
	logic                    wake;
	logic                    req_fire;
	logic                    push;
	logic                    full;
	fetch_pkg::fetch_entry_t entry;

	pc_gen #(
		.BOOT_ADDR(BOOT_ADDR)
	) pc_gen_i (
		.clk      (clk),
		.nrst     (nrst),
		.resp     (resp),
		.redirect (redirect),
		.req_fire (req_fire),
		.fetch_pc (fetch_pc),
		.wake     (wake)
	);

	l15_fetch_port l15_fetch_port_i (
		.clk            (clk),
		.nrst           (nrst),
		.fetch_pc       (fetch_pc),
		.wake           (wake),
		.redirect       (redirect),
		.l15_ack        (l15_ack),
		.l15_header_ack (l15_header_ack),
		.resp           (resp),
		.full           (full),
		.req            (req),
		.l15_req_ack    (l15_req_ack),
		.req_fire       (req_fire),
		.push           (push),
		.entry          (entry)
	);

	// redirect flushes everything fetched down the old path
	fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) fetch_queue_i (
		.clk       (clk),
		.nrst      (nrst),
		.flush     (redirect.valid),
		.push      (push),
		.entry     (entry),
		.out_ready (out_ready),
		.full      (full),
		.out_valid (out_valid),
		.out_entry (out_entry)
	);

endmodule

// File: verilog/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic                    flush,
	input  logic                    push,
	input  fetch_pkg::fetch_entry_t entry,
	input  logic                    out_ready,
	output logic                    full,
	output logic                    out_valid,
	output fetch_pkg::fetch_entry_t out_entry
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	fetch_pkg::fetch_entry_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;   // one extra bit to tell full from empty
	logic             pop;

	assign full      = (count == (PTR_W+1)'(QUEUE_DEPTH));
	assign out_valid = (count != '0);
	assign out_entry = mem[rd_ptr];
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= entry;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0; // a push in the flush cycle is stale anyway
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + PTR_W'(1);
			if (pop)
				rd_ptr <= rd_ptr + PTR_W'(1);
			case ({push, pop})
				2'b10:   count <= count + (PTR_W+1)'(1);
				2'b01:   count <= count - (PTR_W+1)'(1);
				default: count <= count;
			endcase
		end
	end

	// port is expected to stop issuing before the queue fills
	no_overflow: assert property (
		@(posedge clk) disable iff (!nrst)
		push |-> !full
	) else $error("push into full fetch queue");

	// empty queue with nothing pushed stays empty
	no_underflow: assert property (
		@(posedge clk) disable iff (!nrst)
		(count == '0 && !push) |=> (count == '0)
	) else $error("fetch queue count moved while empty");

endmodule

// File: verilog/l15_fetch_port.sv
`timescale 1ns/1ps

module l15_fetch_port (
	input  logic                    clk,
	input  logic                    nrst,
	input  logic [31:0]             fetch_pc,
	input  logic                    wake,
	input  fetch_pkg::redirect_t    redirect,
	input  logic                    l15_ack,
	input  logic                    l15_header_ack,
	input  fetch_pkg::l15_resp_t    resp,
	input  logic                    full,
	output fetch_pkg::l15_req_t     req,
	output logic                    l15_req_ack,
	output logic                    req_fire,
	output logic                    push,
	output fetch_pkg::fetch_entry_t entry
);

	fetch_pkg::port_state_t state;
	logic        req_val;
	logic [31:0] req_addr;  // pc of the outstanding request too
	logic        stale;     // a redirect came after this request
	logic        resp_new;
	logic        resp_take;
	logic        is_fill;

	assign req = '{val: req_val, rqtype: fetch_pkg::rq_imiss, size: 3'd4, address: req_addr};

	assign req_fire = req_val && l15_ack && l15_header_ack;

	// cache keeps val up through our ack cycle, don't count it twice
	assign resp_new  = resp.val && !l15_req_ack;
	assign resp_take = resp_new && (state == fetch_pkg::s_wait);
	assign is_fill   = (resp.returntype == fetch_pkg::ret_ifill) ||
	                   (resp.returntype == fetch_pkg::ret_load);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state   <= fetch_pkg::s_req;
			req_val <= 1'b0;
		end
		else
		begin
			case (state)
				fetch_pkg::s_req:
				begin
					if (req_fire)
					begin
						req_val <= 1'b0;
						state   <= fetch_pkg::s_wait;
					end
					else if (req_val && redirect.valid)
						req_val <= 1'b0; // withdraw, pc is about to change
					else if (!req_val && wake && !full && !redirect.valid)
						req_val <= 1'b1;
				end
				fetch_pkg::s_wait:
				begin
					if (resp_take && is_fill)
						state <= fetch_pkg::s_resp;
				end
				fetch_pkg::s_resp:
					state <= fetch_pkg::s_req; // push happens in this cycle
				default:
					state <= fetch_pkg::s_req;
			endcase
		end
	end

	// follows fetch_pc until val goes up, then frozen until the response
	always_ff @(posedge clk)
	begin
		if ((state == fetch_pkg::s_req) && !req_val)
			req_addr <= fetch_pc;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			stale <= 1'b0;
		else if (req_fire)
			stale <= redirect.valid;
		else if (redirect.valid)
			stale <= 1'b1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			l15_req_ack <= 1'b0;
			push        <= 1'b0;
		end
		else
		begin
			// stray types get acked in s_wait, wake-up in any state
			l15_req_ack <= resp_new && ((state == fetch_pkg::s_wait) ||
			               (resp.returntype == fetch_pkg::ret_int));
			push        <= resp_take && is_fill && !stale && !redirect.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (resp_take)
			entry <= '{pc: req_addr, instr: resp.data};
	end

	// cache may sample the header late, it must not move meanwhile
	req_stable: assert property (
		@(posedge clk) disable iff (!nrst)
		(req_val && !req_fire && !redirect.valid) |=> $stable(req)
	) else $error("request changed before ack, addr %h", req.address);

endmodule

// File: verilog/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
	parameter logic [31:0] BOOT_ADDR = 32'h4000_0000
) (
	input  logic                 clk,
	input  logic                 nrst,
	input  fetch_pkg::l15_resp_t resp,
	input  fetch_pkg::redirect_t redirect,
	input  logic                 req_fire,
	output logic [31:0]          fetch_pc,
	output logic                 wake
);

	logic [31:0] next_pc;
	logic        int_seen;

	// interrupt return from the cache is the wake-up signal
	assign int_seen = resp.val && (resp.returntype == fetch_pkg::ret_int);

	// sticky so fetch never goes back to sleep
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wake <= 1'b0;
		else if (int_seen)
			wake <= 1'b1;
	end

	always_comb
	begin
		if (redirect.valid)
			next_pc = redirect.target; // redirect beats a fire in the same cycle
		else if (req_fire)
			next_pc = fetch_pc + 32'd4;
		else
			next_pc = fetch_pc;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			fetch_pc <= BOOT_ADDR;
		else
			fetch_pc <= next_pc;
	end

	// redirect targets come from outside the core
	pc_aligned: assert property (
		@(posedge clk) disable iff (!nrst)
		fetch_pc[1:0] == 2'b00
	) else $error("fetch_pc not word aligned: %h", fetch_pc);

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// response return types, L1.5 encoding
	localparam logic [3:0] ret_load   = 4'b0000;
	localparam logic [3:0] ret_ifill  = 4'b0001;
	localparam logic [3:0] ret_st_ack = 4'b0100;
	localparam logic [3:0] ret_int    = 4'b0111;
	localparam logic [3:0] ret_err    = 4'b1100;

	// request type for an instruction miss
	localparam logic [4:0] rq_imiss = 5'b10000;

	typedef struct packed {
		logic        val;
		logic [4:0]  rqtype;
		logic [2:0]  size;
		logic [31:0] address;
	} l15_req_t;

	typedef struct packed {
		logic        val;
		logic [3:0]  returntype;
		logic [31:0] data;      // first response word only
	} l15_resp_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_entry_t;

	// request issue, wait for data, hand data to the queue
	typedef enum logic [1:0] {
		s_req  = 2'd0,
		s_wait = 2'd1,
		s_resp = 2'd2
	} port_state_t;

endpackage
